// ==== project.f ====
+incdir+common
common/ctrl_pkg.sv
control_unit/funct_decoder.sv
control_unit/opcode_decoder.sv
control_unit/phase_gate.sv
control_unit/control_unit.sv
bench/control_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= control_unit_tb
LINT_TOP  ?= control_unit
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/control_unit_tb.sv ====
// control unit testbench, walks every encoding through each phase and checks the decode rules
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module control_unit_tb
    import ctrl_pkg::*;
();

    localparam int n_listed = 21;
    localparam int n_walk = (64 + 32 + 62) * 10;  // encodings x phases x wait values
    localparam int n_random = 200;
    localparam int timeout_cycles = 2 * (8 + n_walk + n_random + 4);

    localparam logic [5:0] listed_ops [0:n_listed-1] = '{
        `OP_RTYPE, `OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
        `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
        `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU, `OP_SW
    };

    logic        clk = 1'b0;
    logic        reset;  // holds the assertions off until stimulus runs
    int          errors;
    int          cycles = 0;
    logic [31:0] lcg_state;

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic [`BRANCH_W-1:0] branch_funct;
    phase_t               phase;
    logic                 wait_request;

    alu_op_t alu_op;
    logic    alu_src, jump, branch, mem_read, mem_write, reg_dst, mem_to_reg, reg_write;
    logic    ir_write, pc_to_addr, pc_write, reg_to_jump, md_en, md_signed;
    md_op_t  md_op;
    logic    hi_to_reg, lo_to_reg, link, load_immed;
    ext_op_t ext_op;

    ctrl_word_t actual;
    ctrl_word_t expected;

    control_unit dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic is_listed(input logic [5:0] op);
        logic hit;
        hit = 1'b0;
        foreach (listed_ops[i]) begin
            if (listed_ops[i] == op) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // what the instruction uses, before any timing by phase
    function automatic ctrl_word_t instr_word(input logic [5:0] op, input logic [5:0] fn,
                                              input logic [4:0] br);
        ctrl_word_t w;
        logic       br_link;
        w = '0;
        br_link = br inside {`RI_BLTZAL, `RI_BGEZAL};
        if (op == `OP_RTYPE) begin
            w.alu_op      = alu_funct;
            w.reg_dst     = 1'b1;
            w.reg_write   = fn inside {`FN_ADDU, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU, `FN_SUBU,
                                       `FN_XOR, `FN_SLL, `FN_SRA, `FN_SRL, `FN_SLLV, `FN_SRAV,
                                       `FN_SRLV, `FN_MFHI, `FN_MFLO, `FN_JALR};
            w.jump        = fn inside {`FN_JR, `FN_JALR};
            w.reg_to_jump = w.jump;
            w.link        = (fn == `FN_JALR);
            w.md_en       = fn inside {`FN_MTHI, `FN_MTLO, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};
            w.md_signed   = fn inside {`FN_MULT, `FN_DIV};
            if (fn inside {`FN_MULT, `FN_MULTU}) begin
                w.md_op = md_mult;
            end else if (fn inside {`FN_DIV, `FN_DIVU}) begin
                w.md_op = md_div;
            end else if (fn == `FN_MTLO) begin
                w.md_op = md_mtlo;
            end
            w.hi_to_reg   = (fn == `FN_MFHI);
            w.lo_to_reg   = (fn == `FN_MFLO);
        end else if (op inside {`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI, `OP_SLTIU}) begin
            w.alu_src   = 1'b1;
            w.reg_write = 1'b1;
            case (op)
                `OP_ANDI:  w.alu_op = alu_and;
                `OP_ORI:   w.alu_op = alu_or;
                `OP_XORI:  w.alu_op = alu_xor;
                `OP_SLTI:  w.alu_op = alu_slt;
                `OP_SLTIU: w.alu_op = alu_sltu;
                default:   w.alu_op = alu_add;
            endcase
        end else if (op inside {`OP_LUI, `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW}) begin
            w.alu_src    = 1'b1;
            w.mem_read   = 1'b1;
            w.reg_write  = 1'b1;
            w.load_immed = (op == `OP_LUI);
            w.mem_to_reg = (op == `OP_LW);
            case (op)
                `OP_LB:  w.ext_op = ext_byte_s;
                `OP_LBU: w.ext_op = ext_byte_u;
                `OP_LH:  w.ext_op = ext_half_s;
                `OP_LHU: w.ext_op = ext_half_u;
                default: w.ext_op = ext_none;
            endcase
        end else if (op == `OP_SW) begin
            w.alu_src   = 1'b1;
            w.mem_write = 1'b1;
            w.reg_dst   = 1'b1;
        end else if (op inside {`OP_BEQ, `OP_BNE}) begin
            w.branch = 1'b1;
            w.alu_op = (op == `OP_BEQ) ? alu_eq : alu_ne;
        end else if (op inside {`OP_BGTZ, `OP_BLEZ, `OP_REGIMM}) begin
            w.branch    = 1'b1;
            w.alu_src   = 1'b1;
            w.alu_op    = (op == `OP_BGTZ) ? alu_gtz : (op == `OP_BLEZ) ? alu_lez : alu_regimm;
            w.reg_write = (op == `OP_REGIMM) && br_link;
            w.link      = (op == `OP_REGIMM) && br_link;
        end else if (op inside {`OP_J, `OP_JAL}) begin
            w.jump      = 1'b1;
            w.link      = (op == `OP_JAL);
            w.reg_write = (op == `OP_JAL);
        end
        return w;
    endfunction

    function automatic ctrl_word_t expect_ctrl(input logic [5:0] op, input logic [5:0] fn,
                                               input logic [4:0] br, input phase_t ph,
                                               input logic wr);
        ctrl_word_t w;
        w = '0;
        if (ph == ph_fetch) begin
            w.mem_read   = 1'b1;
            w.pc_to_addr = 1'b1;
        end else if (ph == ph_decode) begin
            w.ir_write   = 1'b1;
            w.pc_to_addr = 1'b1;
        end else begin
            w = instr_word(op, fn, br);
            w.mem_read  = w.mem_read && (ph == ph_exec1);   // address cycle
            w.md_en     = w.md_en && (ph == ph_exec1);
            w.reg_write = w.reg_write && (ph == ph_exec2);  // writeback cycle
            w.mem_write = w.mem_write && (ph == ph_exec2);
        end
        w.pc_write = (ph == ph_exec2) && !wr;
        return w;
    endfunction

    assign actual = {alu_op, alu_src, jump, branch, reg_to_jump, mem_read, mem_write, reg_dst,
                     mem_to_reg, reg_write, ir_write, pc_to_addr, pc_write, md_en, md_signed,
                     md_op, hi_to_reg, lo_to_reg, link, load_immed, ext_op};

    always_comb begin
        expected = expect_ctrl(opcode, funct, branch_funct, phase, wait_request);
    end

    task automatic report_mismatch(input string what, input ctrl_word_t got,
                                   input ctrl_word_t want);
        errors++;
        $display("** Error at %0t: %s, got %h expected %h", $time, what, got, want);
    endtask

    a_override: assert property (@(posedge clk) disable iff (reset)
        phase inside {ph_fetch, ph_decode} |-> actual == expected)
        else report_mismatch("fetch or decode word", $sampled(actual), $sampled(expected));

    a_strobes: assert property (@(posedge clk) disable iff (reset)
        {mem_read, mem_write, reg_write, md_en, ir_write} == {expected.mem_read,
        expected.mem_write, expected.reg_write, expected.md_en, expected.ir_write})
        else report_mismatch("strobe timing", $sampled(actual), $sampled(expected));

    a_pc_write: assert property (@(posedge clk) disable iff (reset)
        pc_write == (phase == ph_exec2 && !wait_request))
        else report_mismatch("pc_write", $sampled(actual), $sampled(expected));

    a_flow: assert property (@(posedge clk) disable iff (reset)
        {alu_op, alu_src, jump, branch, reg_to_jump, link} == {expected.alu_op,
        expected.alu_src, expected.jump, expected.branch, expected.reg_to_jump, expected.link})
        else report_mismatch("ALU or jump select", $sampled(actual), $sampled(expected));

    a_load: assert property (@(posedge clk) disable iff (reset)
        {mem_to_reg, ext_op, load_immed} ==
        {expected.mem_to_reg, expected.ext_op, expected.load_immed})
        else report_mismatch("load select", $sampled(actual), $sampled(expected));

    a_reg_md: assert property (@(posedge clk) disable iff (reset)
        {reg_dst, md_signed, md_op, hi_to_reg, lo_to_reg, pc_to_addr} == {expected.reg_dst,
        expected.md_signed, expected.md_op, expected.hi_to_reg, expected.lo_to_reg,
        expected.pc_to_addr})
        else report_mismatch("register or mul/div select", $sampled(actual), $sampled(expected));

    a_halt: assert property (@(posedge clk) disable iff (reset)
        phase == ph_halt |-> !(mem_read || mem_write || reg_write || ir_write || pc_write || md_en))
        else report_mismatch("strobe in halt", $sampled(actual), $sampled(expected));

    a_unlisted: assert property (@(posedge clk) disable iff (reset)
        (!is_listed(opcode) && phase inside {ph_exec1, ph_exec2})
        |-> !(mem_read || mem_write || reg_write || md_en))
        else report_mismatch("strobe for unlisted opcode", $sampled(actual), $sampled(expected));

    task automatic drive(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] br,
                         input phase_t ph, input logic wr);
        @(posedge clk);
        opcode       <= op;
        funct        <= fn;
        branch_funct <= br;
        phase        <= ph;
        wait_request <= wr;
    endtask

    task automatic walk_phases(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] br);
        for (int p = 0; p < 5; p++) begin
            for (int w = 0; w < 2; w++) begin
                drive(op, fn, br, phase_t'(p[3:0]), w[0]);
            end
        end
    endtask

    initial begin
        int          idx;
        int          ph;
        logic [5:0]  fn_r;
        logic [4:0]  br_r;
        opcode       = '0;
        funct        = '0;
        branch_funct = '0;
        phase        = ph_halt;
        wait_request = 1'b0;
        reset        = 1'b1;
        errors       = 0;
        lcg_state    = 32'd40;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        for (int op = 0; op < 64; op++) begin
            if (op[5:0] == `OP_RTYPE) begin
                for (int fn = 0; fn < 64; fn++) begin
                    walk_phases(op[5:0], fn[5:0], 5'd0);
                end
            end else if (op[5:0] == `OP_REGIMM) begin
                for (int br = 0; br < 32; br++) begin
                    walk_phases(op[5:0], 6'd0, br[4:0]);
                end
            end else begin
                walk_phases(op[5:0], 6'd0, 5'd0);
            end
        end

        for (int i = 0; i < n_random; i++) begin
            lcg_state = lcg_next(lcg_state);
            idx = int'(lcg_state[30:16]) % n_listed;
            lcg_state = lcg_next(lcg_state);
            fn_r = lcg_state[31:26];
            lcg_state = lcg_next(lcg_state);
            br_r = lcg_state[31:27];
            lcg_state = lcg_next(lcg_state);
            ph = int'(lcg_state[30:16]) % 5;
            lcg_state = lcg_next(lcg_state);
            drive(listed_ops[idx], fn_r, br_r, phase_t'(ph[3:0]), lcg_state[31]);
        end

        repeat (2) @(posedge clk);  // let the last inputs be sampled
        $display("Checks finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== control_unit/control_unit.sv ====
// control unit, decodes the current instruction into the multicycle datapath controls
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module control_unit
    import ctrl_pkg::*;
(
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic [`BRANCH_W-1:0] branch_funct,
    input  phase_t               phase,
    input  logic                 wait_request,
    output alu_op_t              alu_op,
    output logic                 alu_src,
    output logic                 jump,
    output logic                 branch,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 reg_dst,
    output logic                 mem_to_reg,
    output logic                 reg_write,
    output logic                 ir_write,
    output logic                 pc_to_addr,
    output logic                 pc_write,
    output logic                 reg_to_jump,
    output logic                 md_en,
    output logic                 md_signed,
    output md_op_t               md_op,
    output logic                 hi_to_reg,
    output logic                 lo_to_reg,
    output logic                 link,
    output logic                 load_immed,
    output ext_op_t              ext_op
);

    funct_class_t cls;
    ctrl_word_t   static_ctrl;
    ctrl_word_t   ctrl;

    funct_decoder funct_decoder_i (
        .funct        (funct),
        .branch_funct (branch_funct),
        .cls          (cls)
    );

    opcode_decoder opcode_decoder_i (
        .opcode      (opcode),
        .cls         (cls),
        .static_ctrl (static_ctrl)
    );

    phase_gate phase_gate_i (
        .phase        (phase),
        .wait_request (wait_request),
        .static_ctrl  (static_ctrl),
        .ctrl         (ctrl)
    );

    assign alu_op      = ctrl.alu_op;
    assign alu_src     = ctrl.alu_src;
    assign jump        = ctrl.jump;
    assign branch      = ctrl.branch;
    assign mem_read    = ctrl.mem_read;
    assign mem_write   = ctrl.mem_write;
    assign reg_dst     = ctrl.reg_dst;
    assign mem_to_reg  = ctrl.mem_to_reg;
    assign reg_write   = ctrl.reg_write;
    assign ir_write    = ctrl.ir_write;
    assign pc_to_addr  = ctrl.pc_to_addr;
    assign pc_write    = ctrl.pc_write;
    assign reg_to_jump = ctrl.reg_to_jump;
    assign md_en       = ctrl.md_en;
    assign md_signed   = ctrl.md_signed;
    assign md_op       = ctrl.md_op;
    assign hi_to_reg   = ctrl.hi_to_reg;
    assign lo_to_reg   = ctrl.lo_to_reg;
    assign link        = ctrl.link;
    assign load_immed  = ctrl.load_immed;
    assign ext_op      = ctrl.ext_op;

endmodule

`default_nettype wire

// ==== control_unit/phase_gate.sv ====
// phase gate, applies the fetch and decode words and times the strobes by phase
`timescale 1ns/10ps
`default_nettype none

module phase_gate
    import ctrl_pkg::*;
(
    input  phase_t     phase,
    input  logic       wait_request,
    input  ctrl_word_t static_ctrl,
    output ctrl_word_t ctrl
);

    always_comb begin
        ctrl = '0;
        case (phase)
            ph_fetch: begin
                ctrl.mem_read   = 1'b1;  // PC drives the memory address
                ctrl.pc_to_addr = 1'b1;
            end
            ph_decode: begin
                ctrl.ir_write   = 1'b1;  // latch the fetched word
                ctrl.pc_to_addr = 1'b1;
            end
            default: begin
                ctrl           = static_ctrl;
                ctrl.ir_write  = 1'b0;
                ctrl.mem_read  = static_ctrl.mem_read && (phase == ph_exec1);
                ctrl.md_en     = static_ctrl.md_en && (phase == ph_exec1);
                ctrl.reg_write = static_ctrl.reg_write && (phase == ph_exec2);
                ctrl.mem_write = static_ctrl.mem_write && (phase == ph_exec2);
            end
        endcase

        // PC only advances once memory is not stalling
        ctrl.pc_write = (phase == ph_exec2) && !wait_request;

        assert (!(ctrl.mem_read && ctrl.mem_write))
            else $error("phase_gate: memory read and write strobes both high");
    end

endmodule

`default_nettype wire

// ==== control_unit/opcode_decoder.sv ====
// opcode decoder, maps the opcode to the controls that do not depend on the phase
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module opcode_decoder
    import ctrl_pkg::*;
(
    input  logic [`OPCODE_W-1:0] opcode,
    input  funct_class_t         cls,
    output ctrl_word_t           static_ctrl
);

    // strobes here mean the instruction uses them; the phase gate times them
    always_comb begin
        static_ctrl = '0;
        case (opcode)
            `OP_RTYPE: begin
                static_ctrl.alu_op      = alu_funct;
                static_ctrl.reg_dst     = 1'b1;  // rd field
                static_ctrl.reg_write   = cls.arith;
                static_ctrl.jump        = cls.reg_jump;
                static_ctrl.reg_to_jump = cls.reg_jump;
                static_ctrl.link        = cls.jump_link;
                static_ctrl.md_en       = cls.mult_div;
                static_ctrl.md_signed   = cls.md_signed;
                static_ctrl.md_op       = cls.op;
                static_ctrl.hi_to_reg   = cls.to_hi;
                static_ctrl.lo_to_reg   = cls.to_lo;
            end
            `OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_SLTI, `OP_SLTIU: begin
                static_ctrl.alu_src   = 1'b1;
                static_ctrl.reg_write = 1'b1;
                case (opcode)
                    `OP_ANDI:  static_ctrl.alu_op = alu_and;
                    `OP_ORI:   static_ctrl.alu_op = alu_or;
                    `OP_XORI:  static_ctrl.alu_op = alu_xor;
                    `OP_SLTI:  static_ctrl.alu_op = alu_slt;
                    `OP_SLTIU: static_ctrl.alu_op = alu_sltu;
                    default:   static_ctrl.alu_op = alu_add;  // ADDIU
                endcase
            end
            `OP_LUI: begin
                static_ctrl.alu_src    = 1'b1;
                static_ctrl.mem_read   = 1'b1;
                static_ctrl.reg_write  = 1'b1;
                static_ctrl.load_immed = 1'b1;  // immediate into the upper half
            end
            `OP_LW: begin
                static_ctrl.alu_src    = 1'b1;
                static_ctrl.mem_read   = 1'b1;
                static_ctrl.reg_write  = 1'b1;
                static_ctrl.mem_to_reg = 1'b1;
            end
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU: begin
                static_ctrl.alu_src   = 1'b1;
                static_ctrl.mem_read  = 1'b1;
                static_ctrl.reg_write = 1'b1;
                case (opcode)
                    `OP_LB:  static_ctrl.ext_op = ext_byte_s;
                    `OP_LBU: static_ctrl.ext_op = ext_byte_u;
                    `OP_LH:  static_ctrl.ext_op = ext_half_s;
                    default: static_ctrl.ext_op = ext_half_u;  // LHU
                endcase
            end
            `OP_SW: begin
                static_ctrl.alu_src   = 1'b1;  // base plus offset
                static_ctrl.mem_write = 1'b1;
                static_ctrl.reg_dst   = 1'b1;
            end
            `OP_BEQ: begin
                static_ctrl.branch = 1'b1;
                static_ctrl.alu_op = alu_eq;
            end
            `OP_BNE: begin
                static_ctrl.branch = 1'b1;
                static_ctrl.alu_op = alu_ne;
            end
            `OP_BGTZ: begin
                static_ctrl.branch  = 1'b1;
                static_ctrl.alu_src = 1'b1;
                static_ctrl.alu_op  = alu_gtz;
            end
            `OP_BLEZ: begin
                static_ctrl.branch  = 1'b1;
                static_ctrl.alu_src = 1'b1;
                static_ctrl.alu_op  = alu_lez;
            end
            `OP_REGIMM: begin
                static_ctrl.branch    = 1'b1;
                static_ctrl.alu_src   = 1'b1;
                static_ctrl.alu_op    = alu_regimm;
                static_ctrl.reg_write = cls.branch_link;  // link writes r31
                static_ctrl.link      = cls.branch_link;
            end
            `OP_J: begin
                static_ctrl.jump = 1'b1;
            end
            `OP_JAL: begin
                static_ctrl.jump      = 1'b1;
                static_ctrl.link      = 1'b1;
                static_ctrl.reg_write = 1'b1;
            end
            default: ;  // LWL, LWR, SB, SH and unknown opcodes stay inactive
        endcase

        assert (!cls.jump_link || cls.reg_jump)
            else $error("opcode_decoder: link request without a register jump");
        assert (!(cls.to_hi || cls.to_lo) || cls.arith)
            else $error("opcode_decoder: HI or LO move without a register write");
    end

endmodule

`default_nettype wire

// ==== control_unit/funct_decoder.sv ====
// function decoder, classifies the R-type function field and the REGIMM branch field
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_consts.svh"

module funct_decoder
    import ctrl_pkg::*;
(
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic [`BRANCH_W-1:0] branch_funct,
    output funct_class_t         cls
);

    always_comb begin
        cls = '0;
        case (funct)
            `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLTU,
            `FN_SLL, `FN_SRA, `FN_SRL, `FN_SLLV, `FN_SRAV, `FN_SRLV: begin
                cls.arith = 1'b1;
            end
            `FN_MFHI: begin
                cls.arith = 1'b1;
                cls.to_hi = 1'b1;
            end
            `FN_MFLO: begin
                cls.arith = 1'b1;
                cls.to_lo = 1'b1;
            end
            `FN_JR: cls.reg_jump = 1'b1;
            `FN_JALR: begin
                cls.arith     = 1'b1;  // return address goes to rd
                cls.reg_jump  = 1'b1;
                cls.jump_link = 1'b1;
            end
            `FN_MTHI, `FN_MTLO: begin
                cls.mult_div = 1'b1;
                cls.op       = (funct == `FN_MTHI) ? md_mthi : md_mtlo;
            end
            `FN_MULT, `FN_MULTU: begin
                cls.mult_div  = 1'b1;
                cls.md_signed = (funct == `FN_MULT);
                cls.op        = md_mult;
            end
            `FN_DIV, `FN_DIVU: begin
                cls.mult_div  = 1'b1;
                cls.md_signed = (funct == `FN_DIV);
                cls.op        = md_div;
            end
            default: ;  // unknown function, no effect
        endcase

        cls.branch_link = (branch_funct == `RI_BLTZAL) || (branch_funct == `RI_BGEZAL);

        assert (!(cls.to_hi && cls.to_lo))
            else $error("funct_decoder: HI and LO moves both selected");
    end

endmodule

`default_nettype wire

// ==== common/ctrl_pkg.sv ====
// control package, with the phase, ALU, extend and mul/div encodings and the control word
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        ph_halt   = 4'd0,
        ph_fetch  = 4'd1,
        ph_decode = 4'd2,
        ph_exec1  = 4'd3,
        ph_exec2  = 4'd4
    } phase_t;

    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_eq     = 4'b0001,  // subtract, zero flag means equal
        alu_funct  = 4'b0010,  // ALU decodes the function field itself
        alu_and    = 4'b0100,
        alu_or     = 4'b0101,
        alu_xor    = 4'b0110,
        alu_slt    = 4'b0111,
        alu_ne     = 4'b1000,
        alu_gtz    = 4'b1001,
        alu_lez    = 4'b1010,
        alu_regimm = 4'b1011,  // condition picked by the branch field
        alu_sltu   = 4'b1100
    } alu_op_t;

    typedef enum logic [2:0] {
        ext_none   = 3'b000,
        ext_half_u = 3'b100,
        ext_half_s = 3'b101,
        ext_byte_u = 3'b110,
        ext_byte_s = 3'b111
    } ext_op_t;

    typedef enum logic [1:0] {
        md_mthi = 2'b00,
        md_mtlo = 2'b01,
        md_mult = 2'b10,
        md_div  = 2'b11
    } md_op_t;

    typedef struct packed {
        logic   arith;        // writes rd
        logic   reg_jump;     // JR, JALR
        logic   jump_link;
        logic   mult_div;
        logic   md_signed;
        logic   to_hi;        // MFHI
        logic   to_lo;        // MFLO
        md_op_t op;
        logic   branch_link;  // REGIMM with link
    } funct_class_t;

    // every datapath control, 27 bits
    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src;
        logic    jump;
        logic    branch;
        logic    reg_to_jump;
        logic    mem_read;
        logic    mem_write;
        logic    reg_dst;
        logic    mem_to_reg;
        logic    reg_write;
        logic    ir_write;
        logic    pc_to_addr;
        logic    pc_write;
        logic    md_en;
        logic    md_signed;
        md_op_t  md_op;
        logic    hi_to_reg;
        logic    lo_to_reg;
        logic    link;
        logic    load_immed;
        ext_op_t ext_op;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== common/ctrl_consts.svh ====
// control constants, instruction field widths and the opcode, function and REGIMM codes
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

`define OPCODE_W 6
`define FUNCT_W  6
`define BRANCH_W 5

// opcodes
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDIU  6'b001001
`define OP_SLTI   6'b001010
`define OP_SLTIU  6'b001011
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_LUI    6'b001111
`define OP_LB     6'b100000
`define OP_LH     6'b100001
`define OP_LWL    6'b100010
`define OP_LW     6'b100011
`define OP_LBU    6'b100100
`define OP_LHU    6'b100101
`define OP_LWR    6'b100110
`define OP_SB     6'b101000
`define OP_SH     6'b101001
`define OP_SW     6'b101011

// R-type function codes
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
`define FN_JR    6'b001000
`define FN_JALR  6'b001001
`define FN_MFHI  6'b010000
`define FN_MTHI  6'b010001
`define FN_MFLO  6'b010010
`define FN_MTLO  6'b010011
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

// REGIMM branch field (rt)
`define RI_BLTZ   5'b00000
`define RI_BGEZ   5'b00001
`define RI_BLTZAL 5'b10000
`define RI_BGEZAL 5'b10001

`endif
